// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := board_io_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps
PASS_MSG   := TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/board_if.sv ====
// Board I/O interfaces

interface wb_if import board_pkg::*; ();

    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat_w;
    logic [WB_DAT_W-1:0] dat_r;
    logic                ack;

    // Pin side of the bus
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

interface phy_ctrl_if import board_pkg::*; ();

    led_src_e           led_src;
    logic [LED_W-1:0]   led_user;
    logic               clr;
    logic [DROPS_W-1:0] link_drops;
    logic               link_lost;

    modport regs (
        output led_src, led_user, clr,
        input  link_drops, link_lost
    );

    modport mon (
        input  led_src, led_user, clr,
        output link_drops, link_lost
    );

endinterface

// ==== design/board_io.sv ====
// Board I/O top level

module board_io import board_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pll_locked,
    input  logic [NUM_BTN-1:0]  btn,
    input  logic [NUM_SW-1:0]   sw,
    output logic [NUM_BTN-1:0]  btn_db,
    output logic [NUM_SW-1:0]   sw_db,
    input  logic                uart_rxd,
    input  logic                uart_rts,
    output logic                uart_rxd_sync,
    output logic                uart_rts_sync,
    input  logic [STATUS_W-1:0] pcs_status,
    output logic [4:0]          pcs_config,
    output logic                phy_reset_n,
    output logic [LED_W-1:0]    led,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack,
    output logic                core_rst_n
);

    logic                rst_n;
    logic [STATUS_W-1:0] status_sync;

    wb_if       wb_bus ();
    phy_ctrl_if phy_ctl ();

    reset_sync u_reset_sync (
        .clk    (clk),
        .arst_n (arst_n),
        .locked (pll_locked),
        .rst_n  (rst_n)
    );

    assign core_rst_n = rst_n;

    // Buttons in the upper GPIO bits
    debounce_switch #(
        .WIDTH (NUM_BTN + NUM_SW),
        .N     (DEBOUNCE_N),
        .RATE  (DEBOUNCE_RATE)
    ) u_debounce (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_sig  ({btn, sw}),
        .out_sig ({btn_db, sw_db})
    );

    signal_sync #(.WIDTH(2), .STAGES(SYNC_STAGES)) u_uart_sync (
        .clk     (clk),
        .in_sig  ({uart_rxd, uart_rts}),
        .out_sig ({uart_rxd_sync, uart_rts_sync})
    );

    // PCS/PMA status vector is quasi-static
    signal_sync #(.WIDTH(STATUS_W), .STAGES(SYNC_STAGES)) u_status_sync (
        .clk     (clk),
        .in_sig  (pcs_status),
        .out_sig (status_sync)
    );

    // Pin side of the Wishbone bus
    assign wb_bus.cyc   = wb_cyc;
    assign wb_bus.stb   = wb_stb;
    assign wb_bus.we    = wb_we;
    assign wb_bus.adr   = wb_adr;
    assign wb_bus.dat_w = wb_dat_w;
    assign wb_dat_r     = wb_bus.dat_r;
    assign wb_ack       = wb_bus.ack;

    board_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb          (wb_bus.slave),
        .ctl         (phy_ctl.regs),
        .btn_db      (btn_db),
        .sw_db       (sw_db),
        .status      (status_sync),
        .phy_reset_n (phy_reset_n),
        .pcs_config  (pcs_config)
    );

    phy_status_mon u_mon (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctl    (phy_ctl.mon),
        .status (status_sync),
        .sw_db  (sw_db),
        .led    (led)
    );

endmodule

// ==== design/board_pkg.sv ====
// Board I/O shared definitions
package board_pkg;

    // Wishbone bus
    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 32;

    // Register word addresses
    localparam logic [WB_ADR_W-1:0] ADR_ID   = 4'd0;
    localparam logic [WB_ADR_W-1:0] ADR_CTRL = 4'd1;
    localparam logic [WB_ADR_W-1:0] ADR_LED  = 4'd2;
    localparam logic [WB_ADR_W-1:0] ADR_GPIO = 4'd3;
    localparam logic [WB_ADR_W-1:0] ADR_PHY  = 4'd4;

    localparam logic [WB_DAT_W-1:0] BOARD_ID = 32'hB0A2_D10F;

    // CTRL layout with led_src in 1:0, phy_reset_n in 2 and pcs_config in 12:8
    // Reset keeps the PHY in reset with autonegotiation enabled
    localparam logic [WB_DAT_W-1:0] CTRL_RESET = 32'h0000_1000;
    localparam logic [WB_DAT_W-1:0] CTRL_MASK  = 32'h0000_1F07;

    // Board I/O widths
    localparam int NUM_BTN  = 5;
    localparam int NUM_SW   = 4;
    localparam int STATUS_W = 16;
    localparam int LED_W    = 8;
    localparam int DROPS_W  = 8;

    // Synchronizer depths
    localparam int RESET_STAGES = 4;
    localparam int SYNC_STAGES  = 2;

    // Debounce timing short enough for simulation
    localparam int DEBOUNCE_RATE = 8;
    localparam int DEBOUNCE_N    = 4;

    // LED source select
    typedef enum logic [1:0] {
        LED_USER    = 2'd0,
        LED_STAT_LO = 2'd1,
        LED_STAT_HI = 2'd2,
        LED_SWITCH  = 2'd3
    } led_src_e;

endpackage

// ==== design/board_regs.sv ====
// Wishbone board register block

module board_regs import board_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    wb_if.slave                 wb,
    phy_ctrl_if.regs            ctl,
    input  logic [NUM_BTN-1:0]  btn_db,
    input  logic [NUM_SW-1:0]   sw_db,
    input  logic [STATUS_W-1:0] status,
    output logic                phy_reset_n,
    output logic [4:0]          pcs_config
);

    logic                wb_req;
    logic                wb_wr;
    logic                ack_q;
    logic                clr_q;
    logic [WB_DAT_W-1:0] ctrl_q;
    logic [LED_W-1:0]    led_q;
    logic [WB_DAT_W-1:0] rd_data;
    logic [WB_DAT_W-1:0] dat_r_q;

    // New access while no ack is pending
    assign wb_req = wb.cyc && wb.stb && !ack_q;
    assign wb_wr  = wb_req && wb.we;

    // Control state and single-cycle ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q  <= 1'b0;
            clr_q  <= 1'b0;
            ctrl_q <= CTRL_RESET;
            led_q  <= '0;
        end else begin
            ack_q <= wb_req;
            // Any write to PHY status clears the link monitor
            clr_q <= wb_wr && (wb.adr == ADR_PHY);
            if (wb_wr) begin
                case (wb.adr)
                    ADR_CTRL: begin
                        ctrl_q <= wb.dat_w & CTRL_MASK;
                    end
                    ADR_LED: begin
                        led_q <= wb.dat_w[LED_W-1:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Unmapped addresses read zero
    always_comb begin
        rd_data = '0;
        case (wb.adr)
            ADR_ID: begin
                rd_data = BOARD_ID;
            end
            ADR_CTRL: begin
                rd_data = ctrl_q;
            end
            ADR_LED: begin
                rd_data = WB_DAT_W'(led_q);
            end
            ADR_GPIO: begin
                rd_data[NUM_BTN-1:0] = btn_db;
                rd_data[8 +: NUM_SW] = sw_db;
            end
            ADR_PHY: begin
                rd_data[STATUS_W-1:0]   = status;
                rd_data[16 +: DROPS_W]  = ctl.link_drops;
                rd_data[24]             = ctl.link_lost;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    // Read data captured with the access and held while ack is high
    always_ff @(posedge clk) begin
        if (wb_req) begin
            dat_r_q <= rd_data;
        end
    end

    assign wb.ack   = ack_q;
    assign wb.dat_r = dat_r_q;

    // Control fields
    assign ctl.led_src  = led_src_e'(ctrl_q[1:0]);
    assign ctl.led_user = led_q;
    assign ctl.clr      = clr_q;
    assign phy_reset_n  = ctrl_q[2];
    assign pcs_config   = ctrl_q[12:8];

endmodule

// ==== design/debounce_switch.sv ====
// Button and switch debouncer

module debounce_switch #(
    parameter int WIDTH = 1,
    parameter int N     = 4,
    parameter int RATE  = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] in_sig,
    output logic [WIDTH-1:0] out_sig
);

    localparam int CNT_W = (RATE > 1) ? $clog2(RATE) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic             tick;
    logic [N-1:0]     hist_q [WIDTH];
    logic [N-1:0]     hist_d [WIDTH];

    // One sample tick every RATE clocks
    assign tick = (cnt_q == CNT_W'(RATE - 1));

    // Newest sample enters at bit 0
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            hist_d[i] = (hist_q[i] << 1) | N'(in_sig[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            out_sig <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                hist_q[i] <= '0;
            end
        end else begin
            cnt_q <= tick ? '0 : cnt_q + 1'b1;
            if (tick) begin
                for (int i = 0; i < WIDTH; i++) begin
                    hist_q[i] <= hist_d[i];
                    // Change only once all N samples agree
                    if (&hist_d[i]) begin
                        out_sig[i] <= 1'b1;
                    end else if (~|hist_d[i]) begin
                        out_sig[i] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== design/phy_status_mon.sv ====
// PHY link status monitor

module phy_status_mon import board_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    phy_ctrl_if.mon             ctl,
    input  logic [STATUS_W-1:0] status,
    input  logic [NUM_SW-1:0]   sw_db,
    output logic [LED_W-1:0]    led
);

    logic               link_q;
    logic               link_fall;
    logic [DROPS_W-1:0] drops_q;
    logic               lost_q;
    logic [LED_W-1:0]   led_d;

    // Status bit 0 is link up
    assign link_fall = link_q && !status[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            link_q  <= 1'b0;
            drops_q <= '0;
            lost_q  <= 1'b0;
            led     <= '0;
        end else begin
            link_q <= status[0];
            led    <= led_d;
            // Clear wins over a drop on the same clock
            if (ctl.clr) begin
                drops_q <= '0;
                lost_q  <= 1'b0;
            end else if (link_fall) begin
                lost_q <= 1'b1;
                if (drops_q != '1) begin
                    drops_q <= drops_q + 1'b1;
                end
            end
        end
    end

    // LED source select
    always_comb begin
        case (ctl.led_src)
            LED_USER:    led_d = ctl.led_user;
            LED_STAT_LO: led_d = status[LED_W-1:0];
            LED_STAT_HI: led_d = status[STATUS_W-1 -: LED_W];
            // Board switches where sw[3] enables status and sw[0] picks the byte
            default: begin
                if (!sw_db[3]) begin
                    led_d = ctl.led_user;
                end else if (sw_db[0]) begin
                    led_d = status[STATUS_W-1 -: LED_W];
                end else begin
                    led_d = status[LED_W-1:0];
                end
            end
        endcase
    end

    assign ctl.link_drops = drops_q;
    assign ctl.link_lost  = lost_q;

endmodule

// ==== design/reset_sync.sv ====
// Core reset synchronizer

module reset_sync import board_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic locked,
    output logic rst_n
);

    // Either source clears the chain at once
    logic                    clr_n;
    logic [RESET_STAGES-1:0] sync_q;

    assign clr_n = arst_n & locked;

    // Ones shift in after both sources are high
    always_ff @(posedge clk or negedge clr_n) begin
        if (!clr_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[RESET_STAGES-2:0], 1'b1};
        end
    end

    assign rst_n = sync_q[RESET_STAGES-1];

endmodule

// ==== design/signal_sync.sv ====
// Flip-flop synchronizer

module signal_sync #(
    parameter int WIDTH  = 1,
    parameter int STAGES = 2
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] in_sig,
    output logic [WIDTH-1:0] out_sig
);

    // Stage 0 is the metastable capture flop
    logic [WIDTH-1:0] sync_q [STAGES];

    always_ff @(posedge clk) begin
        sync_q[0] <= in_sig;
        for (int i = 1; i < STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    assign out_sig = sync_q[STAGES-1];

endmodule

// ==== dv/board_io_wb_tasks.svh ====
// Wishbone master tasks

// Classic write held until the slave acknowledges
task automatic write_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] data);
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    @(negedge clk);
    while (!wb_ack) begin
        @(negedge clk);
    end
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

// Classic read with data taken while ack is high
task automatic read_reg(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack) begin
        @(negedge clk);
    end
    data = wb_dat_r;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
endtask

task automatic read_check(input string name, input logic [WB_ADR_W-1:0] adr,
                          input logic [WB_DAT_W-1:0] exp);
    logic [WB_DAT_W-1:0] data;
    read_reg(adr, data);
    check_value(name, exp, data);
endtask

// ==== dv/board_io_tb.sv ====
// Board I/O testbench

module board_io_tb import board_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // Register test spans about 300 cycles, debounce 400, LED source 700, the rest
    // a few hundred more; the limit leaves a wide margin over that
    localparam int CYCLE_LIMIT = 20000;
    localparam int HOLD_CLKS   = DEBOUNCE_RATE * (DEBOUNCE_N + 1);

    // CTRL fields led_src 1:0, phy_reset_n 2 and pcs_config 12:8
    localparam logic [31:0] CTRL_FIELDS = 32'h0000_1F07;

    logic clk;
    logic arst_n = 1'b0;
    logic pll_locked = 1'b0;
    logic [NUM_BTN-1:0] btn = '0;
    logic [NUM_SW-1:0] sw = '0;
    logic [NUM_BTN-1:0] btn_db;
    logic [NUM_SW-1:0] sw_db;
    logic uart_rxd = 1'b0;
    logic uart_rts = 1'b0;
    logic uart_rxd_sync;
    logic uart_rts_sync;
    logic [STATUS_W-1:0] pcs_status = '0;
    logic [4:0] pcs_config;
    logic phy_reset_n;
    logic [LED_W-1:0] led;
    logic wb_cyc = 1'b0;
    logic wb_stb = 1'b0;
    logic wb_we = 1'b0;
    logic [WB_ADR_W-1:0] wb_adr = '0;
    logic [WB_DAT_W-1:0] wb_dat_w = '0;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic wb_ack;
    logic core_rst_n;
    int cycle_cnt = 0;
    logic [1:0] rxd_hist = '0;
    logic [1:0] rts_hist = '0;

    board_io DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else report_failure($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Low through the first RESET_STAGES edges, high after the last
    task automatic check_release();
        for (int i = 0; i <= RESET_STAGES; i++) begin
            @(negedge clk);
            check_value("reset_release", 32'(i == RESET_STAGES), 32'(core_rst_n));
        end
    endtask

    task automatic settle_gpio(input logic [8:0] val);
        wait_cycles(1);
        {btn, sw} = val;
        wait_cycles(HOLD_CLKS);
    endtask

    // Byte shown on the LEDs for a given source
    function automatic logic [7:0] led_expected(input logic [1:0] src, input logic [7:0] user,
                                                input logic [15:0] stat, input logic [3:0] sw_val);
        case (src)
            2'd0: return user;
            2'd1: return stat[7:0];
            2'd2: return stat[15:8];
            default: begin
                if (!sw_val[3]) begin
                    return user;
                end
                return sw_val[0] ? stat[15:8] : stat[7:0];
            end
        endcase
    endfunction

    `include "board_io_wb_tasks.svh"

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            report_failure("Timeout: the run went past its cycle limit");
        end
    end

    // UART lines appear two clocks later
    always @(negedge clk) begin
        if (core_rst_n) begin
            check_value("uart_rxd", 32'(rxd_hist[1]), 32'(uart_rxd_sync));
            check_value("uart_rts", 32'(rts_hist[1]), 32'(uart_rts_sync));
        end
        rxd_hist <= {rxd_hist[0], uart_rxd};
        rts_hist <= {rts_hist[0], uart_rts};
    end

    ack_one_cycle: assert property (@(negedge clk) disable iff (!core_rst_n)
        wb_ack |=> !wb_ack)
    else report_failure("Error ack_width: expected 0, actual 1");

    ack_after_stb: assert property (@(negedge clk) disable iff (!core_rst_n)
        $rose(wb_stb) |=> wb_ack)
    else report_failure("Error ack_latency: expected 1, actual 0");

    lock_drop: assert property (@(negedge clk) !pll_locked |-> !core_rst_n)
    else report_failure("Error lock_drop: expected 0, actual 1");

    initial begin
        logic [WB_DAT_W-1:0] data;
        logic [8:0] gpio;
        logic [15:0] stat;
        logic [7:0] user;
        int drops;
        void'($urandom(2));
        wait_cycles(2);
        arst_n = 1'b1;
        pll_locked = 1'b1;
        check_release();
        check_value("led_reset", 32'h0, 32'(led));
        check_value("phy_reset_n_reset", 32'h0, 32'(phy_reset_n));
        check_value("pcs_config_reset", 32'h10, 32'(pcs_config));
        check_value("wb_ack_reset", 32'h0, 32'(wb_ack));

        // Lock loss resets the core without waiting for a clock
        wait_cycles(1);
        pll_locked = 1'b0;
        #1;
        check_value("lock_drop", 32'h0, 32'(core_rst_n));
        wait_cycles(1);
        pll_locked = 1'b1;
        check_release();

        read_check("id", ADR_ID, BOARD_ID);
        repeat (4) begin
            data = $urandom;
            write_reg(ADR_CTRL, data);
            read_check("ctrl_readback", ADR_CTRL, data & CTRL_FIELDS);
            check_value("phy_reset_n", 32'(data[2]), 32'(phy_reset_n));
            check_value("pcs_config", 32'(data[12:8]), 32'(pcs_config));
            data = $urandom;
            write_reg(ADR_LED, data);
            read_check("led_readback", ADR_LED, {24'h0, data[7:0]});
        end
        for (int a = 5; a < 16; a++) begin
            write_reg(a[3:0], $urandom);
            read_check("unused_addr", a[3:0], 32'h0);
        end

        repeat (3) begin
            gpio = 9'($urandom);
            settle_gpio(gpio);
            check_value("btn_db", 32'(gpio[8:4]), 32'(btn_db));
            check_value("sw_db", 32'(gpio[3:0]), 32'(sw_db));
            read_check("gpio_reg", ADR_GPIO, {20'h0, gpio[3:0], 3'b0, gpio[8:4]});
            // Glitches step through every phase of the sample tick
            for (int g = 0; g < DEBOUNCE_RATE; g++) begin
                wait_cycles(1);
                {btn, sw} = gpio ^ 9'($urandom | 1);
                wait_cycles(1);
                {btn, sw} = gpio;
                repeat (DEBOUNCE_RATE) begin
                    @(negedge clk);
                    check_value("glitch", 32'(gpio), 32'({btn_db, sw_db}));
                end
            end
        end

        // Switch modes only matter for the switch-selected source
        for (int src = 0; src < 4; src++) begin
            for (int k = 0; k < 3; k++) begin
                user = 8'($urandom);
                stat = 16'($urandom);
                gpio = 9'($urandom);
                gpio[3] = (k != 0);
                gpio[0] = (k == 2);
                write_reg(ADR_LED, 32'(user));
                write_reg(ADR_CTRL, {19'h0, 5'h10, 5'h0, 1'b1, 2'(src)});
                pcs_status = stat;
                settle_gpio(gpio);
                @(negedge clk);
                check_value("led_src", 32'(led_expected(2'(src), user, stat, gpio[3:0])),
                            32'(led));
            end
        end

        wait_cycles(1);
        pcs_status[0] = 1'b1;
        wait_cycles(4);
        write_reg(ADR_PHY, 32'h0);
        drops = $urandom_range(6, 1);
        repeat (drops) begin
            pcs_status[0] = 1'b0;
            wait_cycles(3);
            pcs_status[0] = 1'b1;
            wait_cycles(3);
        end
        read_reg(ADR_PHY, data);
        check_value("link_status", 32'(pcs_status), 32'(data[15:0]));
        check_value("link_drops", 32'(drops), 32'(data[23:16]));
        check_value("link_lost", 32'h1, 32'(data[24]));
        write_reg(ADR_PHY, $urandom);
        read_reg(ADR_PHY, data);
        check_value("link_clear", 32'h0, 32'(data[24:16]));

        repeat (64) begin
            wait_cycles(1);
            uart_rxd = 1'($urandom);
            uart_rts = 1'($urandom);
        end
        wait_cycles(4);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+dv
design/board_pkg.sv
design/board_if.sv
design/reset_sync.sv
design/signal_sync.sv
design/debounce_switch.sv
design/board_regs.sv
design/phy_status_mon.sv
design/board_io.sv
dv/board_io_tb.sv
